/* build.f */
rtl/execPkg.sv
rtl/memPkg.sv
rtl/mathUnit.sv
rtl/loadStoreUnit.sv
rtl/memArbiter.sv
rtl/dataMemory.sv
rtl/execUnit.sv
tests/clockGen.sv
tests/execUnitTb.sv

/* rtl/dataMemory.sv */
////////////////////////////////////////
// Single-port data memory, starts at zero
// Write on the edge, read data registered
// and valid one cycle after the address
////////////////////////////////////////

module dataMemory (
	input							clock,
	input	logic					write,
	input	memPkg::addr_t			addr,
	input	execPkg::data_t			writeData,
	output	execPkg::data_t			readData
);

	import execPkg::*;
	import memPkg::*;

	data_t							mem [MEM_WORDS] = '{ default: '0 };

	always_ff @( posedge clock ) begin
		if ( write ) begin
			mem[addr]		<= writeData;
		end
		readData			<= mem[addr];		// Old word on a write cycle
	end

endmodule

/* rtl/execPkg.sv */
////////////////////////////////////////
// Widths, types and opcodes shared by the
// execution cluster. Imported by the math
// pipeline, the load/store lanes and the top
////////////////////////////////////////

package execPkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int DATA_WIDTH	= 32;			// Operand and result word
	localparam int REG_WIDTH	= 5;			// 32 architectural registers
	localparam int OP_WIDTH		= 3;			// Command opcode field
	localparam int MATH_DEPTH	= 3;			// Math pipeline stages

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [DATA_WIDTH-1:0]	data_t;		// Operands, results, memory words
	typedef logic [REG_WIDTH-1:0]	regIdx_t;	// Destination register number

	// Command opcodes, opNop leaves every path idle
	typedef enum logic [OP_WIDTH-1:0] {
		opNop,
		opAdd,
		opSub,
		opMul,
		opMove,
		opLoad,
		opStore
	} opcode_t;

endpackage

/* rtl/execUnit.sv */
////////////////////////////////////////
// Top of the execution cluster. Decodes one
// command per cycle into the math pipeline,
// the move path or a load/store lane, and
// ties the lanes to the shared memory
////////////////////////////////////////

module execUnit (
	input							clock,
	input							reset,
	input	logic					enable,			// Command strobe
	input	execPkg::opcode_t		opcode,
	input	execPkg::regIdx_t		dst,
	input	execPkg::data_t			operandA,
	input	execPkg::data_t			operandB,
	input	memPkg::addr_t			addr,			// Bit 0 picks the lane
	output	logic					mathDone,
	output	execPkg::regIdx_t		mathDst,
	output	execPkg::data_t			mathData,
	output	logic					moveDone,
	output	execPkg::regIdx_t		moveDst,
	output	execPkg::data_t			moveData,
	output	logic					loadDone0,
	output	logic					loadDone1,
	output	execPkg::regIdx_t		loadDst0,
	output	execPkg::regIdx_t		loadDst1,
	output	execPkg::data_t			loadData0,
	output	execPkg::data_t			loadData1,
	output	logic					storeDone0,
	output	logic					storeDone1,
	output	logic					laneBusy0,
	output	logic					laneBusy1
);

	import execPkg::*;
	import memPkg::*;

	logic							mathStart;
	logic							moveStart;
	logic							lsStart;
	logic							isStore;
	logic	[LANES-1:0]				laneRequest;
	logic	[LANES-1:0]				laneGrant;
	logic							laneWrite0;
	logic							laneWrite1;
	addr_t							laneAddr0;
	addr_t							laneAddr1;
	data_t							laneWriteData0;
	data_t							laneWriteData1;
	logic							memWrite;
	addr_t							memAddr;
	data_t							memWriteData;
	data_t							memReadData;

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////

	assign mathStart		= enable & ( opcode == opAdd || opcode == opSub || opcode == opMul );
	assign moveStart		= enable & ( opcode == opMove );
	assign lsStart			= enable & ( opcode == opLoad || opcode == opStore );
	assign isStore			= ( opcode == opStore );

	// Register move path, one cycle
	always_ff @( posedge clock ) begin
		if ( reset ) begin
			moveDone		<= 1'b0;
		end
		else begin
			moveDone		<= moveStart;
		end
	end

	always_ff @( posedge clock ) begin
		moveDst				<= dst;
		moveData			<= operandA;
	end

	////////////////////////////////////////
	// Execution paths
	////////////////////////////////////////

	mathUnit mathUnit (
		.clock(				clock					),
		.reset(				reset					),
		.start(				mathStart				),
		.op(				opcode					),
		.dst(				dst						),
		.operandA(			operandA				),
		.operandB(			operandB				),
		.done(				mathDone				),
		.resultDst(			mathDst					),
		.result(			mathData				)
	);

	// Store data comes from operandA, as in the move path
	loadStoreUnit lane0 (
		.clock(				clock					),
		.reset(				reset					),
		.start(				lsStart & ~addr[0]		),
		.isStore(			isStore					),
		.dst(				dst						),
		.addr(				addr					),
		.storeData(			operandA				),
		.request(			laneRequest[0]			),
		.grant(				laneGrant[0]			),
		.memWrite(			laneWrite0				),
		.memAddr(			laneAddr0				),
		.memWriteData(		laneWriteData0			),
		.memReadData(		memReadData				),
		.busy(				laneBusy0				),
		.loadDone(			loadDone0				),
		.storeDone(			storeDone0				),
		.loadDst(			loadDst0				),
		.loadData(			loadData0				)
	);

	loadStoreUnit lane1 (
		.clock(				clock					),
		.reset(				reset					),
		.start(				lsStart & addr[0]		),
		.isStore(			isStore					),
		.dst(				dst						),
		.addr(				addr					),
		.storeData(			operandA				),
		.request(			laneRequest[1]			),
		.grant(				laneGrant[1]			),
		.memWrite(			laneWrite1				),
		.memAddr(			laneAddr1				),
		.memWriteData(		laneWriteData1			),
		.memReadData(		memReadData				),
		.busy(				laneBusy1				),
		.loadDone(			loadDone1				),
		.storeDone(			storeDone1				),
		.loadDst(			loadDst1				),
		.loadData(			loadData1				)
	);

	////////////////////////////////////////
	// Shared memory port
	////////////////////////////////////////

	memArbiter memArbiter (
		.clock(				clock					),
		.reset(				reset					),
		.request(			laneRequest				),
		.grant(				laneGrant				),
		.laneWrite0(		laneWrite0				),
		.laneWrite1(		laneWrite1				),
		.laneAddr0(			laneAddr0				),
		.laneAddr1(			laneAddr1				),
		.laneWriteData0(	laneWriteData0			),
		.laneWriteData1(	laneWriteData1			),
		.memWrite(			memWrite				),
		.memAddr(			memAddr					),
		.memWriteData(		memWriteData			)
	);

	dataMemory dataMemory (
		.clock(				clock					),
		.write(				memWrite				),
		.addr(				memAddr					),
		.writeData(			memWriteData			),
		.readData(			memReadData				)
	);

endmodule

/* rtl/loadStoreUnit.sv */
////////////////////////////////////////
// One load/store lane. Holds a single
// pending access, requests the shared port
// until granted, and writes back loads
////////////////////////////////////////

module loadStoreUnit (
	input							clock,
	input							reset,
	input	logic					start,			// New access for this lane
	input	logic					isStore,
	input	execPkg::regIdx_t		dst,
	input	memPkg::addr_t			addr,
	input	execPkg::data_t			storeData,
	output	logic					request,		// Held until granted
	input	logic					grant,
	output	logic					memWrite,
	output	memPkg::addr_t			memAddr,
	output	execPkg::data_t			memWriteData,
	input	execPkg::data_t			memReadData,	// Shared by both lanes
	output	logic					busy,
	output	logic					loadDone,
	output	logic					storeDone,
	output	execPkg::regIdx_t		loadDst,
	output	execPkg::data_t			loadData
);

	import execPkg::*;
	import memPkg::*;

	typedef enum logic [1:0] {
		lsIdle,
		lsRequest,
		lsRead
	} lsState_t;

	lsState_t						state;
	logic							pendStore;		// Pending access
	regIdx_t						pendDst;
	addr_t							pendAddr;
	data_t							pendData;

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			state			<= lsIdle;
			loadDone		<= 1'b0;
			storeDone		<= 1'b0;
		end
		else begin
			loadDone		<= 1'b0;
			storeDone		<= 1'b0;
			case ( state )
				lsIdle: begin
					if ( start ) state <= lsRequest;
				end
				lsRequest: begin
					if ( grant ) begin
						state		<= isStoreNext( pendStore );
						storeDone	<= pendStore;		// Write lands on the grant edge
					end
				end
				lsRead: begin
					state			<= lsIdle;
					loadDone		<= 1'b1;
				end
				default: state		<= lsIdle;
			endcase
		end
	end

	// Stores finish at the grant, loads wait for the read data
	function automatic lsState_t isStoreNext( input logic store );
		return store ? lsIdle : lsRead;
	endfunction

	////////////////////////////////////////
	// Pending access and load capture
	////////////////////////////////////////

	always_ff @( posedge clock ) begin
		if ( state == lsIdle && start ) begin
			pendStore		<= isStore;
			pendDst			<= dst;
			pendAddr		<= addr;
			pendData		<= storeData;
		end
		if ( state == lsRead ) begin
			loadData		<= memReadData;		// Memory output one cycle after grant
		end
	end

	assign busy				= ( state != lsIdle );
	assign request			= ( state == lsRequest );
	assign memWrite			= pendStore & request;
	assign memAddr			= pendAddr;
	assign memWriteData		= pendData;
	assign loadDst			= pendDst;

endmodule

/* rtl/mathUnit.sv */
////////////////////////////////////////
// Three-stage integer math pipeline
// Takes one add, sub or mul per cycle and
// returns the result three cycles later
////////////////////////////////////////

module mathUnit (
	input							clock,
	input							reset,
	input	logic					start,			// Accept a math command
	input	execPkg::opcode_t		op,
	input	execPkg::regIdx_t		dst,
	input	execPkg::data_t			operandA,
	input	execPkg::data_t			operandB,
	output	logic					done,			// Result valid
	output	execPkg::regIdx_t		resultDst,
	output	execPkg::data_t			result
);

	import execPkg::*;

	logic	[MATH_DEPTH-1:0]		validChain;		// One bit per stage
	regIdx_t						dstChain [MATH_DEPTH];

	opcode_t						opOne;			// Stage one registers
	data_t							aOne;
	data_t							bOne;
	data_t							calcTwo;		// Stage two input, combinational
	data_t							resultTwo;
	data_t							resultThree;

	////////////////////////////////////////
	// Valid and destination chain
	////////////////////////////////////////

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			validChain		<= '0;
		end
		else begin
			validChain		<= { validChain[MATH_DEPTH-2:0], start };
		end
	end

	always_ff @( posedge clock ) begin
		dstChain[0]			<= dst;
		for ( int i = 1; i < MATH_DEPTH; i++ ) begin
			dstChain[i]		<= dstChain[i-1];
		end
	end

	////////////////////////////////////////
	// Data stages
	////////////////////////////////////////

	// Low 32 bits only, the product wraps like the sum
	always_comb begin
		case ( opOne )
			opAdd:		calcTwo = aOne + bOne;
			opSub:		calcTwo = aOne - bOne;
			opMul:		calcTwo = aOne * bOne;
			default:	calcTwo = '0;
		endcase
	end

	always_ff @( posedge clock ) begin
		opOne				<= op;				// Stage one
		aOne				<= operandA;
		bOne				<= operandB;
		resultTwo			<= calcTwo;			// Stage two
		resultThree			<= resultTwo;		// Stage three
	end

	assign done				= validChain[MATH_DEPTH-1];
	assign resultDst		= dstChain[MATH_DEPTH-1];
	assign result			= resultThree;

endmodule

/* rtl/memArbiter.sv */
////////////////////////////////////////
// Round-robin arbiter for the shared data
// memory port. Grants one lane per cycle
// and muxes it onto the memory
////////////////////////////////////////

module memArbiter (
	input								clock,
	input								reset,
	input	logic [memPkg::LANES-1:0]	request,		// Level per lane
	output	logic [memPkg::LANES-1:0]	grant,			// One-hot, same cycle
	input	logic						laneWrite0,
	input	logic						laneWrite1,
	input	memPkg::addr_t				laneAddr0,
	input	memPkg::addr_t				laneAddr1,
	input	execPkg::data_t				laneWriteData0,
	input	execPkg::data_t				laneWriteData1,
	output	logic						memWrite,
	output	memPkg::addr_t				memAddr,
	output	execPkg::data_t				memWriteData
);

	logic								lastServed;		// Lane granted most recently

	// On a tie the lane not served last wins
	assign grant[0]			= request[0] & ( ~request[1] |  lastServed );
	assign grant[1]			= request[1] & ( ~request[0] | ~lastServed );

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			lastServed		<= 1'b1;			// Lane 0 wins the first tie
		end
		else if ( |grant ) begin
			lastServed		<= grant[1];
		end
	end

	////////////////////////////////////////
	// Port mux
	////////////////////////////////////////

	assign memWrite			= ( grant[1] ) ?	laneWrite1 :
								( grant[0] ) ?	laneWrite0 :
												1'b0;		// No write without a grant
	assign memAddr			= ( grant[1] ) ?	laneAddr1 :
												laneAddr0;
	assign memWriteData		= ( grant[1] ) ?	laneWriteData1 :
												laneWriteData0;

endmodule

/* rtl/memPkg.sv */
////////////////////////////////////////
// Data memory geometry and arbiter sizing
// Used by the lanes, the arbiter, the memory
////////////////////////////////////////

package memPkg;

	localparam int ADDR_WIDTH	= 8;					// Word address bits
	localparam int MEM_WORDS	= 1 << ADDR_WIDTH;		// 256 words
	localparam int LANES		= 2;					// Load/store lanes on the port

	typedef logic [ADDR_WIDTH-1:0]	addr_t;				// Word address

endpackage

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	-f build.f --top-module execUnitTb -o simExec

# The simulator exits nonzero on a failed check, the log decides the result
./obj_dir/simExec | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

/* tests/clockGen.sv */
////////////////////////////////////////
// Testbench clock and reset source
// 4 ns clock, reset high for two edges
////////////////////////////////////////

module clockGen (
	output	logic	clock,
	output	logic	reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock		= 1'b0;
		forever #2 clock = ~clock;			// 4 ns period
	end

	initial begin
		reset		= 1'b1;
		repeat ( 2 ) @( posedge clock );
		#1 reset	= 1'b0;					// Released off the edge
	end

endmodule

/* tests/execStim.txt */
# Columns in hex: opcode dst operandA operandB addr rand expected
# Opcodes 0 nop 1 add 2 sub 3 mul 4 move 5 load 6 store, rand 1 means random operands
0 00 00000000 00000000 00 0 00000000
0 00 00000000 00000000 00 0 00000000
1 01 ffffffff 00000002 00 0 00000001
2 02 00000005 00000007 00 0 fffffffe
3 03 00010000 00010000 00 0 00000000
3 04 12345678 00000009 00 0 a3d70a38
4 05 cafef00d 00000000 00 0 cafef00d
1 06 7fffffff 00000001 00 0 80000000
4 07 0000beef 12345678 00 0 0000beef
6 00 deadbeef 00000000 10 0 00000000
5 08 00000000 00000000 10 0 deadbeef
6 00 0badf00d 00000000 21 0 00000000
5 09 00000000 00000000 21 0 0badf00d
1 15 00000003 00000004 00 0 00000007
2 16 00000003 00000004 00 0 ffffffff
5 0a 00000000 00000000 10 0 deadbeef
5 0b 00000000 00000000 21 0 0badf00d
5 0c 00000000 00000000 7e 0 00000000
5 0d 00000000 00000000 ff 0 00000000
1 0e 00000000 00000000 00 1 00000000
3 0f 00000000 00000000 00 1 00000000
2 10 00000000 00000000 00 1 00000000
4 11 00000000 00000000 00 1 00000000
6 00 00000000 00000000 42 1 00000000
5 12 00000000 00000000 42 1 00000000
5 13 00000000 00000000 43 0 00000000
2 14 00000064 00000001 00 0 00000063

/* tests/execUnitTb.sv */
////////////////////////////////////////
// Testbench for the execution cluster
// Reads commands from tests/execStim.txt,
// models math, move and memory results and
// checks every write-back port each cycle
////////////////////////////////////////

module execUnitTb;

	timeunit 1ns;
	timeprecision 100ps;

	import execPkg::*;
	import memPkg::*;

	typedef struct packed {
		logic [2:0]		op;
		regIdx_t		dst;
		data_t			operandA;
		data_t			operandB;
		addr_t			addr;
		logic			rnd;			// Operands from $random
		data_t			expected;
	} command_t;

	typedef struct packed {
		int				due;			// Cycle of the done pulse
		regIdx_t		dst;
		data_t			data;
	} result_t;

	typedef struct packed {
		int				issue;			// Cycle the command was driven
		int				due;			// Cycle of the done pulse
		logic			lane;
		logic			isStore;
		regIdx_t		dst;
		data_t			data;
	} laneItem_t;

	logic clock, reset, enable;
	opcode_t opcode;
	regIdx_t dst, mathDst, moveDst, loadDst0, loadDst1;
	data_t operandA, operandB, mathData, moveData, loadData0, loadData1;
	addr_t addr;
	logic mathDone, moveDone, loadDone0, loadDone1, storeDone0, storeDone1;
	logic laneBusy0, laneBusy1;

	command_t	commands [$];
	result_t	mathQ [$];
	result_t	moveQ [$];
	laneItem_t	laneQ [$];				// Both lanes, oldest first
	data_t		modelMem [MEM_WORDS];
	int			seed		= 32'h7701cbf3;
	int			cycle		= 0;
	int			cycleLimit	= 0;

	clockGen clockGen ( .clock( clock ), .reset( reset ) );

	execUnit i_dut (
		.clock( clock ), .reset( reset ), .enable( enable ), .opcode( opcode ),
		.dst( dst ), .operandA( operandA ), .operandB( operandB ), .addr( addr ),
		.mathDone( mathDone ), .mathDst( mathDst ), .mathData( mathData ),
		.moveDone( moveDone ), .moveDst( moveDst ), .moveData( moveData ),
		.loadDone0( loadDone0 ), .loadDone1( loadDone1 ),
		.loadDst0( loadDst0 ), .loadDst1( loadDst1 ),
		.loadData0( loadData0 ), .loadData1( loadData1 ),
		.storeDone0( storeDone0 ), .storeDone1( storeDone1 ),
		.laneBusy0( laneBusy0 ), .laneBusy1( laneBusy1 )
	);

	task automatic failRun( input string why );
		$display( "%s", why );
		$display( "FAIL: see errors above" );
		$fatal( 1 );
	endtask

	task automatic checkValue( input string name, input data_t actual, input data_t expected );
		if ( actual !== expected ) begin
			failRun( $sformatf( "FAIL %s: got %h, expected %h", name, actual, expected ) );
		end
	endtask

	// Wrapped 32-bit results
	function automatic data_t mathModel( input opcode_t op, input data_t a, input data_t b );
		case ( op )
			opAdd:		return a + b;
			opSub:		return a - b;
			default:	return a * b;
		endcase
	endfunction

	function automatic int firstOnLane( input logic lane );
		int idx;
		idx = -1;
		foreach ( laneQ[k] ) begin
			if ( idx < 0 && laneQ[k].lane == lane ) idx = k;
		end
		return idx;
	endfunction

	task automatic loadStimulus();
		int fd;
		int count;
		string line;
		logic [31:0] f [7];
		command_t cmd;
		fd = $fopen( "tests/execStim.txt", "r" );
		if ( fd == 0 ) failRun( "Could not open the stimulus file tests/execStim.txt" );
		while ( !$feof( fd ) ) begin
			line = "";
			void'( $fgets( line, fd ) );
			if ( line.len() > 0 && line.getc( 0 ) != "#" ) begin
				count = $sscanf( line, "%h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6] );
				if ( count == 7 ) begin
					cmd.op			= f[0][2:0];
					cmd.dst			= f[1][4:0];
					cmd.operandA	= f[2];
					cmd.operandB	= f[3];
					cmd.addr		= f[4][7:0];
					cmd.rnd			= f[5][0];
					cmd.expected	= f[6];
					commands.push_back( cmd );
				end
				else if ( count > 0 ) begin
					failRun( "The stimulus file has a line with missing columns" );
				end
			end
		end
		$fclose( fd );
	endtask

	// Waits for a free lane on loads and stores, then drives one command
	task automatic issueCommand( input command_t cmd );
		opcode_t op;
		data_t a;
		data_t b;
		data_t expected;
		result_t res;
		laneItem_t item;
		op = opcode_t'( cmd.op );
		a = cmd.operandA;
		b = cmd.operandB;
		if ( cmd.rnd ) begin
			a = $random( seed );
			b = $random( seed );
		end
		@( posedge clock );
		#1;
		while ( ( op == opLoad || op == opStore ) &&
				( cmd.addr[0] ? laneBusy1 : laneBusy0 ) ) begin
			enable = 1'b0;
			@( posedge clock );
			#1;
		end
		case ( op )
			opAdd, opSub, opMul:	expected = mathModel( op, a, b );
			opMove:					expected = a;
			opLoad:					expected = modelMem[cmd.addr];
			default:				expected = '0;
		endcase
		if ( !cmd.rnd && op != opNop && op != opStore ) begin
			checkValue( "stimExpected", expected, cmd.expected );	// File against model
		end
		if ( op == opStore ) modelMem[cmd.addr] = a;
		enable		= 1'b1;
		opcode		= op;
		dst			= cmd.dst;
		operandA	= a;
		operandB	= b;
		addr		= cmd.addr;
		res.dst		= cmd.dst;
		res.data	= expected;
		if ( op == opAdd || op == opSub || op == opMul ) begin
			res.due = cycle + MATH_DEPTH;
			mathQ.push_back( res );
		end
		if ( op == opMove ) begin
			res.due = cycle + 1;
			moveQ.push_back( res );
		end
		if ( op == opLoad || op == opStore ) begin
			// One command per cycle keeps the lane requests apart
			// Grant right after the accept edge, store done next, load data one later
			item.issue		= cycle;
			item.due		= cycle + ( ( op == opStore ) ? 2 : 3 );
			item.lane		= cmd.addr[0];
			item.isStore	= ( op == opStore );
			item.dst		= cmd.dst;
			item.data		= expected;
			laneQ.push_back( item );
		end
	endtask

	task automatic checkPipes();
		logic due;
		due = mathQ.size() > 0 && mathQ[0].due == cycle;
		checkValue( "mathDone", 32'( mathDone ), 32'( due ) );
		if ( due ) begin
			checkValue( "mathDst", 32'( mathDst ), 32'( mathQ[0].dst ) );
			checkValue( "mathData", mathData, mathQ[0].data );
			void'( mathQ.pop_front() );
		end
		due = moveQ.size() > 0 && moveQ[0].due == cycle;
		checkValue( "moveDone", 32'( moveDone ), 32'( due ) );
		if ( due ) begin
			checkValue( "moveDst", 32'( moveDst ), 32'( moveQ[0].dst ) );
			checkValue( "moveData", moveData, moveQ[0].data );
			void'( moveQ.pop_front() );
		end
	endtask

	// Each lane finishes its own accesses in issue order
	task automatic checkLane( input logic lane, input logic ldDone, input logic stDone,
			input regIdx_t ldDst, input data_t ldData, input logic busy );
		int idx;
		logic busyDue;
		idx = firstOnLane( lane );
		if ( ldDone || stDone ) begin
			if ( idx < 0 ) begin
				failRun( $sformatf( "Lane %0d finished an access that was never issued",
					lane ) );
			end
			else begin
				checkValue( $sformatf( "storeDone%0d", lane ), 32'( stDone ),
					32'( laneQ[idx].isStore ) );
				checkValue( $sformatf( "loadDone%0d", lane ), 32'( ldDone ),
					32'( !laneQ[idx].isStore ) );
				checkValue( $sformatf( "%s%0d cycle", stDone ? "storeDone" : "loadDone",
					lane ), cycle, laneQ[idx].due );
				if ( ldDone ) begin
					checkValue( $sformatf( "loadDst%0d", lane ), 32'( ldDst ),
						32'( laneQ[idx].dst ) );
					checkValue( $sformatf( "loadData%0d", lane ), ldData, laneQ[idx].data );
				end
				laneQ.delete( idx );
			end
		end
		idx = firstOnLane( lane );
		busyDue = idx >= 0 && cycle > laneQ[idx].issue;		// High from the accept edge
		checkValue( $sformatf( "laneBusy%0d", lane ), 32'( busy ), 32'( busyDue ) );
	endtask

	always @( posedge clock ) begin
		cycle <= cycle + 1;
		if ( cycleLimit > 0 && cycle >= cycleLimit ) begin
			failRun( $sformatf( "Timeout: the run did not finish within %0d cycles", cycleLimit ) );
		end
	end

	// Outputs are stable mid-cycle
	always @( negedge clock ) begin
		if ( !reset ) begin
			checkPipes();
			checkLane( 1'b0, loadDone0, storeDone0, loadDst0, loadData0, laneBusy0 );
			checkLane( 1'b1, loadDone1, storeDone1, loadDst1, loadData1, laneBusy1 );
		end
	end

	initial begin
		enable		= 1'b0;
		opcode		= opNop;
		dst			= '0;
		operandA	= '0;
		operandB	= '0;
		addr		= '0;
		foreach ( modelMem[i] ) modelMem[i] = '0;		// Memory starts cleared
		loadStimulus();
		cycleLimit	= 16 * commands.size() + 100;
		wait ( reset == 1'b0 );
		foreach ( commands[i] ) issueCommand( commands[i] );
		@( posedge clock );
		#1;
		enable		= 1'b0;
		opcode		= opNop;
		while ( mathQ.size() > 0 || moveQ.size() > 0 || laneQ.size() > 0 ) begin
			@( posedge clock );
		end
		repeat ( 4 ) @( posedge clock );				// Catch late stray pulses
		$display( "PASS: all tests" );
		$finish;
	end

endmodule
